//--- hw/apb_map_pkg.sv
package apb_map_pkg;

        localparam int amba_word       = 32;
        localparam int amba_addr_width = 20;

        localparam logic [amba_addr_width-1:0] ctrl_addr           = 20'h00;
        localparam logic [amba_addr_width-1:0] data_in_addr        = 20'h04;
        localparam logic [amba_addr_width-1:0] codeword_width_addr = 20'h08;
        localparam logic [amba_addr_width-1:0] noise_addr          = 20'h0C;

        // 3 is handled like op_encode
        typedef enum logic [1:0] {
                op_encode  = 2'd0,
                op_decode  = 2'd1,
                op_channel = 2'd2
        } ecc_op_e;

endpackage

//--- hw/apb_reg_bank.sv
`timescale 1ns/100ps

module apb_reg_bank (
        input  logic                                    clk,
        input  logic                                    rst,
        input  logic                                    psel,
        input  logic                                    penable,
        input  logic                                    pwrite,
        input  logic [apb_map_pkg::amba_addr_width-1:0] paddr,
        input  logic [apb_map_pkg::amba_word-1:0]       pwdata,
        output logic [apb_map_pkg::amba_word-1:0]       prdata,
        ecc_ctrl_if.reg_bank                            ctl
);
        import apb_map_pkg::*;
        import ecc_code_pkg::*;

        logic [1:0]            ctrl_q;
        logic [data_width-1:0] data_in_q;
        logic [1:0]            width_q;
        logic [data_width-1:0] noise_q;
        logic                  start_q;
        logic                  wr_en;

        assign wr_en = psel & penable & pwrite;

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        ctrl_q    <= '0;
                        data_in_q <= '0;
                        width_q   <= '0;
                        noise_q   <= '0;
                        start_q   <= 1'b0;
                end else begin
                        start_q <= 1'b0;
                        if (wr_en) begin
                                case (paddr)
                                        ctrl_addr: begin
                                                ctrl_q  <= pwdata[1:0];
                                                start_q <= 1'b1;   // kicks the datapath
                                        end
                                        data_in_addr:        data_in_q <= pwdata[data_width-1:0];
                                        codeword_width_addr: width_q   <= pwdata[1:0];
                                        noise_addr:          noise_q   <= pwdata[data_width-1:0];
                                        default: ;
                                endcase
                        end
                end
        end

        // zero wait state read, unmapped reads zero
        always_comb begin
                prdata = '0;
                if (psel && !pwrite) begin
                        case (paddr)
                                ctrl_addr:           prdata = amba_word'(ctrl_q);
                                data_in_addr:        prdata = amba_word'(data_in_q);
                                codeword_width_addr: prdata = amba_word'(width_q);
                                noise_addr:          prdata = amba_word'(noise_q);
                                default:             prdata = '0;
                        endcase
                end
        end

        assign ctl.start   = start_q;
        assign ctl.op      = ecc_op_e'(ctrl_q);
        assign ctl.mode    = ecc_width_e'(width_q);
        assign ctl.data_in = data_in_q;
        assign ctl.noise   = noise_q;

endmodule

//--- hw/ecc_code_pkg.sv
package ecc_code_pkg;

        localparam int data_width       = 32;
        localparam int max_parity_width = 6;    // overall parity included
        localparam int max_info_width   = 26;

        typedef enum logic [1:0] {
                width_8  = 2'd0,
                width_16 = 2'd1,
                width_32 = 2'd2
        } ecc_width_e;

        // codeword length, 3 falls through to 32
        function automatic int code_len(ecc_width_e mode);
                case (mode)
                        width_8:  return 8;
                        width_16: return 16;
                        default:  return 32;
                endcase
        endfunction

        // parity positions of the hamming part
        function automatic bit is_pow2(int p);
                return (p & (p - 1)) == 0;
        endfunction

endpackage

//--- hw/ecc_codec_top.sv
`timescale 1ns/100ps

module ecc_codec_top (
        input  logic                                    clk,
        input  logic                                    rst,
        input  logic [apb_map_pkg::amba_addr_width-1:0] paddr,
        input  logic                                    psel,
        input  logic                                    penable,
        input  logic                                    pwrite,
        input  logic [apb_map_pkg::amba_word-1:0]       pwdata,
        output logic [apb_map_pkg::amba_word-1:0]       prdata,
        output logic [ecc_code_pkg::data_width-1:0]     data_out,
        output logic                                    operation_done,
        output logic [1:0]                              num_of_errors
);

        ecc_ctrl_if ctl_if ();

        apb_reg_bank u_regs (
                .clk     (clk),
                .rst     (rst),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .paddr   (paddr),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .ctl     (ctl_if.reg_bank)
        );

        // encoder and decoder live in here
        ecc_datapath u_dp (
                .clk            (clk),
                .rst            (rst),
                .ctl            (ctl_if.datapath),
                .data_out       (data_out),
                .operation_done (operation_done),
                .num_of_errors  (num_of_errors)
        );

endmodule

//--- hw/ecc_ctrl_if.sv
`timescale 1ns/100ps

interface ecc_ctrl_if;
        import ecc_code_pkg::*;
        import apb_map_pkg::*;

        logic                  start;   // one cycle per ctrl write
        ecc_op_e               op;
        ecc_width_e            mode;
        logic [data_width-1:0] data_in;
        logic [data_width-1:0] noise;

        // fields only meaningful while start is high
        modport reg_bank (
                output start,
                output op,
                output mode,
                output data_in,
                output noise
        );

        modport datapath (
                input start,
                input op,
                input mode,
                input data_in,
                input noise
        );

endinterface

//--- hw/ecc_datapath.sv
`timescale 1ns/100ps

module ecc_datapath (
        input  logic                                clk,
        input  logic                                rst,
        ecc_ctrl_if.datapath                        ctl,
        output logic [ecc_code_pkg::data_width-1:0] data_out,
        output logic                                operation_done,
        output logic [1:0]                          num_of_errors
);
        import ecc_code_pkg::*;
        import apb_map_pkg::*;

        logic                  is_dec;
        logic                  enc_in_valid;
        logic                  enc_valid;
        logic [data_width-1:0] enc_cw;
        ecc_op_e               s1_op;
        ecc_width_e            s1_mode;
        logic [data_width-1:0] s1_noise;
        logic                  dec_in_valid;
        ecc_width_e            dec_mode;
        logic [data_width-1:0] dec_word;
        logic                  dec_valid;
        logic [data_width-1:0] dec_info;
        logic [1:0]            dec_errs;

        assign is_dec       = (ctl.op == op_decode);
        assign enc_in_valid = ctl.start & ~is_dec;

        ecc_encoder u_enc (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (enc_in_valid),
                .mode      (ctl.mode),
                .info      (ctl.data_in),
                .out_valid (enc_valid),
                .codeword  (enc_cw)
        );

        // op, mode and noise ride along with the encoder stage
        always_ff @(posedge clk or negedge rst) begin
                if (!rst)
                        s1_op <= op_encode;
                else if (enc_in_valid)
                        s1_op <= ctl.op;
        end

        always_ff @(posedge clk) begin
                if (enc_in_valid) begin
                        s1_mode  <= ctl.mode;
                        s1_noise <= ctl.noise;
                end
        end

        always_comb begin
                if (ctl.start && is_dec) begin
                        dec_in_valid = 1'b1;    // straight from the bank
                        dec_mode     = ctl.mode;
                        dec_word     = ctl.data_in;
                end else begin
                        dec_in_valid = enc_valid && (s1_op == op_channel);
                        dec_mode     = s1_mode;
                        dec_word     = enc_cw ^ s1_noise;   // channel noise
                end
        end

        ecc_decoder u_dec (
                .clk           (clk),
                .rst           (rst),
                .in_valid      (dec_in_valid),
                .mode          (dec_mode),
                .received      (dec_word),
                .out_valid     (dec_valid),
                .info          (dec_info),
                .num_of_errors (dec_errs)
        );

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        data_out       <= '0;
                        num_of_errors  <= '0;
                        operation_done <= 1'b0;
                end else begin
                        operation_done <= 1'b0;
                        if (dec_valid) begin
                                data_out       <= dec_info;
                                num_of_errors  <= dec_errs;
                                operation_done <= 1'b1;
                        end else if (enc_valid && s1_op != op_channel) begin
                                data_out       <= enc_cw;  // encode only, op 3 too
                                num_of_errors  <= '0;
                                operation_done <= 1'b1;
                        end
                end
        end

endmodule

//--- hw/ecc_decoder.sv
`timescale 1ns/100ps

module ecc_decoder (
        input  logic                                clk,
        input  logic                                rst,
        input  logic                                in_valid,
        input  ecc_code_pkg::ecc_width_e            mode,
        input  logic [ecc_code_pkg::data_width-1:0] received,
        output logic                                out_valid,
        output logic [ecc_code_pkg::data_width-1:0] info,
        output logic [1:0]                          num_of_errors
);
        import ecc_code_pkg::*;

        logic [data_width-1:0]         word_c;
        logic [max_parity_width-2:0]   syn_c;
        logic                          par_c;

        logic                          s1_valid;
        logic [data_width-1:0]         s1_word;
        logic [max_parity_width-2:0]   s1_syn;
        logic                          s1_par;
        ecc_width_e                    s1_mode;

        logic [data_width-1:0]         fixed_c;
        logic [max_info_width-1:0]     info_c;
        logic [1:0]                    errs_c;

        // stage one, syndrome and overall parity
        always_comb begin
                int n;

                n      = code_len(mode);
                word_c = '0;
                syn_c  = '0;
                for (int p = 0; p < data_width; p++) begin
                        if (p < n)
                                word_c[p] = received[p];   // drop bits above width
                end
                for (int p = 1; p < data_width; p++) begin
                        if (word_c[p])
                                syn_c ^= (max_parity_width - 1)'(p);
                end
                par_c = ^word_c;
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        s1_valid  <= 1'b0;
                        out_valid <= 1'b0;
                end else begin
                        s1_valid  <= in_valid;
                        out_valid <= s1_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid) begin
                        s1_word <= word_c;
                        s1_syn  <= syn_c;
                        s1_par  <= par_c;
                        s1_mode <= mode;
                end
        end

        // stage two, correct then gather
        always_comb begin
                int n;
                int k;

                n       = code_len(s1_mode);
                fixed_c = s1_word;
                if (s1_par) begin
                        errs_c          = 2'd1;
                        fixed_c[s1_syn] = ~s1_word[s1_syn];   // syn 0 hits overall parity
                end else if (s1_syn != '0) begin
                        errs_c = 2'd2;  // double error, left as is
                end else begin
                        errs_c = 2'd0;
                end
                info_c = '0;
                k      = 0;
                for (int p = 3; p < data_width; p++) begin
                        if (!is_pow2(p)) begin
                                if (p < n)
                                        info_c[k] = fixed_c[p];
                                k++;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (s1_valid) begin
                        info          <= data_width'(info_c);
                        num_of_errors <= errs_c;
                end
        end

endmodule

//--- hw/ecc_encoder.sv
`timescale 1ns/100ps

module ecc_encoder (
        input  logic                                clk,
        input  logic                                rst,
        input  logic                                in_valid,
        input  ecc_code_pkg::ecc_width_e            mode,
        input  logic [ecc_code_pkg::data_width-1:0] info,
        output logic                                out_valid,
        output logic [ecc_code_pkg::data_width-1:0] codeword
);
        import ecc_code_pkg::*;

        logic [data_width-1:0] cw;

        always_comb begin
                int   n;
                int   k;
                logic par;

                n  = code_len(mode);
                cw = '0;
                k  = 0;
                // info bits fill the non power of two slots in order
                for (int p = 3; p < data_width; p++) begin
                        if (!is_pow2(p)) begin
                                if (p < n)
                                        cw[p] = info[k];
                                k++;
                        end
                end
                for (int i = 0; i < max_parity_width - 1; i++) begin
                        par = 1'b0;
                        for (int p = 1; p < data_width; p++) begin
                                if (p[i])
                                        par ^= cw[p];
                        end
                        if ((1 << i) < n)
                                cw[1 << i] = par;
                end
                cw[0] = ^cw;    // overall parity, whole word xors to zero
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst)
                        out_valid <= 1'b0;
                else
                        out_valid <= in_valid;
        end

        always_ff @(posedge clk) begin
                if (in_valid)
                        codeword <= cw;
        end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the ecc codec testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f vlog.f --top-module ecc_codec_tb \
        -Mdir obj_dir -o ecc_codec_sim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/ecc_codec_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -qx "Testbench passed" "$log"; then
        exit 0
else
        echo "pass message not found in $log"
        exit 1
fi

//--- verification/ecc_codec_tb.sv
`timescale 1ns/100ps

module ecc_codec_tb;
        import apb_map_pkg::*;

        localparam int period          = 20;
        localparam int reset_cycles    = 16;
        localparam int enc_per_width   = 8;
        localparam int clean_per_width = 4;
        localparam int dbl_per_width   = 8;
        localparam int chan_per_mask   = 4;
        localparam int op_cycles       = 12;   // three writes, latency, one idle
        localparam int num_ops = 3 * (enc_per_width + clean_per_width + dbl_per_width)
                + (8 + 16 + 32) + 9 * chan_per_mask + 3;
        localparam int watchdog_ns = 2 * period * (reset_cycles + 40 + num_ops * op_cycles);

        logic        clk;
        logic        rst;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [19:0] paddr;
        logic [31:0] pwdata;
        logic [31:0] prdata;
        logic [31:0] data_out;
        logic        operation_done;
        logic [1:0]  num_of_errors;
        logic [31:0] lcg_state;

        // write order ends on ctrl so the last write starts an op
        logic [19:0] reg_addrs [4] = '{data_in_addr, codeword_width_addr, noise_addr, ctrl_addr};
        logic [31:0] reg_masks [4] = '{32'hffff_ffff, 32'h3, 32'hffff_ffff, 32'h3};
        logic [19:0] bad_addrs [3] = '{20'h10, 20'h80, 20'hffffc};

        ecc_codec_top UUT (
                .clk            (clk),
                .rst            (rst),
                .paddr          (paddr),
                .psel           (psel),
                .penable        (penable),
                .pwrite         (pwrite),
                .pwdata         (pwdata),
                .prdata         (prdata),
                .data_out       (data_out),
                .operation_done (operation_done),
                .num_of_errors  (num_of_errors)
        );

        always #(period / 2) clk = ~clk;

        function automatic logic [31:0] next_rand();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        function automatic int rand_below(input int n);
                return int'((next_rand() >> 16) % 32'(n));   // upper bits, better spread
        endfunction

        function automatic int cw_len(input int w);
                case (w)
                        0:       return 8;
                        1:       return 16;
                        default: return 32;
                endcase
        endfunction

        function automatic logic [31:0] info_mask(input int w);
                case (w)
                        0:       return 32'h0000_000f;
                        1:       return 32'h0000_07ff;
                        default: return 32'h03ff_ffff;
                endcase
        endfunction

        // parity bits chosen so the xor of all set positions is zero
        function automatic logic [31:0] model_encode(input int w, input logic [31:0] info);
                logic [31:0] cw;
                logic [4:0]  syn;
                int          n;
                int          k;

                n   = cw_len(w);
                cw  = '0;
                syn = '0;
                k   = 0;
                for (int p = 1; p < n; p++) begin
                        if ((p & (p - 1)) != 0) begin
                                cw[p] = info[k];
                                if (info[k])
                                        syn ^= p[4:0];
                                k++;
                        end
                end
                for (int i = 0; i < 5; i++) begin
                        if ((1 << i) < n)
                                cw[1 << i] = syn[i];
                end
                cw[0] = ^cw;
                return cw;
        endfunction

        task automatic check_equal(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                assert (act === exp) else begin
                        $display("ERROR %s expected %0h actual %0h", name, exp, act);
                        $display("Testbench failed");
                        $fatal(1);
                end
        endtask

        // called on a falling edge, returns on the falling edge after the write edge
        task automatic apb_write(input logic [19:0] addr, input logic [31:0] data);
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = 1'b1;
                paddr   = addr;
                pwdata  = data;
                @(negedge clk);
                penable = 1'b1;
                @(negedge clk);
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
        endtask

        task automatic apb_read(input logic [19:0] addr, output logic [31:0] data);
                psel    = 1'b1;
                penable = 1'b0;
                pwrite  = 1'b0;
                paddr   = addr;
                @(negedge clk);
                penable = 1'b1;
                #(period / 4) data = prdata;   // mid low phase
                @(negedge clk);
                psel    = 1'b0;
                penable = 1'b0;
        endtask

        task automatic wait_done(output int lat);
                lat = 0;
                while (!operation_done && lat <= 10) begin
                        @(negedge clk);
                        lat++;
                end
                if (!operation_done) begin
                        $display("operation_done did not pulse within 10 cycles of the ctrl write");
                        $display("Testbench failed");
                        $fatal(1);
                end
        endtask

        task automatic start_op(input logic [1:0] op, input logic [31:0] data,
                                input logic [31:0] noise);
                apb_write(data_in_addr, data);
                apb_write(noise_addr, noise);
                apb_write(ctrl_addr, 32'(op));
        endtask

        // lat_exp below zero skips the latency check
        task automatic expect_result(input string name, input int lat_exp,
                                     input logic [31:0] exp_data, input logic [1:0] exp_errs,
                                     input bit data_known);
                int lat;

                wait_done(lat);
                if (lat_exp >= 0)
                        check_equal({name, " latency"}, 32'(lat_exp), 32'(lat));
                if (data_known)
                        check_equal({name, " data_out"}, exp_data, data_out);
                check_equal({name, " errors"}, 32'(exp_errs), 32'(num_of_errors));
                @(negedge clk);
        endtask

        initial begin
                #(watchdog_ns);
                $display("watchdog expired, the tests ran far longer than expected");
                $display("Testbench failed");
                $fatal(1);
        end

        initial begin
                logic [31:0] info;
                logic [31:0] cw;
                logic [31:0] noise;
                logic [31:0] rd;
                logic [31:0] wr_vals [4];
                int          n;
                int          p1;
                int          p2;
                string       tag;

                clk       = 1'b0;
                rst       = 1'b0;
                psel      = 1'b0;
                penable   = 1'b0;
                pwrite    = 1'b0;
                paddr     = '0;
                pwdata    = '0;
                lcg_state = 32'h26ca;
                repeat (reset_cycles) @(negedge clk);
                rst = 1'b1;
                @(negedge clk);

                // reset values, register readback, unmapped offsets
                check_equal("reset done", 32'h0, 32'(operation_done));
                check_equal("reset data_out", 32'h0, data_out);
                check_equal("reset errors", 32'h0, 32'(num_of_errors));
                for (int i = 0; i < 4; i++) begin
                        apb_read(reg_addrs[i], rd);
                        check_equal("reset register", 32'h0, rd);
                end
                for (int i = 0; i < 4; i++) begin
                        wr_vals[i] = next_rand();
                        apb_write(reg_addrs[i], wr_vals[i]);
                end
                wait_done(p1);   // random op, only the pulse matters here
                @(negedge clk);
                for (int i = 0; i < 4; i++) begin
                        apb_read(reg_addrs[i], rd);
                        check_equal("register readback", wr_vals[i] & reg_masks[i], rd);
                end
                for (int i = 0; i < 3; i++) begin
                        apb_read(bad_addrs[i], rd);
                        check_equal("unmapped read", 32'h0, rd);
                end

                for (int w = 0; w < 3; w++) begin
                        n = cw_len(w);
                        apb_write(codeword_width_addr, 32'(w));

                        tag = $sformatf("encode w%0d", n);
                        for (int j = 0; j < enc_per_width; j++) begin
                                info = next_rand();
                                start_op(op_encode, info, 32'h0);
                                expect_result(tag, 2, model_encode(w, info), 2'd0, 1'b1);
                        end

                        tag = $sformatf("decode clean w%0d", n);
                        for (int j = 0; j < clean_per_width; j++) begin
                                info = next_rand();
                                start_op(op_decode, model_encode(w, info), 32'h0);
                                expect_result(tag, 3, info & info_mask(w), 2'd0, 1'b1);
                        end

                        tag = $sformatf("decode single w%0d", n);
                        for (int pos = 0; pos < n; pos++) begin
                                info = next_rand();
                                cw   = model_encode(w, info) ^ (32'h1 << pos);
                                start_op(op_decode, cw, 32'h0);
                                expect_result(tag, 3, info & info_mask(w), 2'd1, 1'b1);
                        end

                        tag = $sformatf("decode double w%0d", n);
                        for (int j = 0; j < dbl_per_width; j++) begin
                                info = next_rand();
                                p1   = rand_below(n);
                                p2   = p1;
                                while (p2 == p1)
                                        p2 = rand_below(n);
                                cw = model_encode(w, info) ^ (32'h1 << p1) ^ (32'h1 << p2);
                                start_op(op_decode, cw, 32'h0);
                                expect_result(tag, 3, 32'h0, 2'd2, 1'b0);
                        end

                        for (int m = 0; m < 3; m++) begin
                                tag = $sformatf("channel w%0d noise%0d", n, m);
                                for (int j = 0; j < chan_per_mask; j++) begin
                                        info  = next_rand();
                                        p1    = rand_below(n);
                                        p2    = p1;
                                        while (p2 == p1)
                                                p2 = rand_below(n);
                                        noise = 32'h0;
                                        if (m > 0)
                                                noise |= 32'h1 << p1;
                                        if (m > 1)
                                                noise |= 32'h1 << p2;
                                        start_op(op_channel, info, noise);
                                        expect_result(tag, 4, info & info_mask(w), 2'(m), m < 2);
                                end
                        end
                end

                // two channel ops in flight, data_in rewritten between them
                info  = next_rand();
                cw    = ~info ^ (next_rand() & 32'h00ff_0000);   // low half always differs
                noise = 32'h1 << rand_below(32);
                apb_write(noise_addr, noise);
                apb_write(data_in_addr, info);
                apb_write(ctrl_addr, 32'(op_channel));
                apb_write(data_in_addr, cw);
                apb_write(ctrl_addr, 32'(op_channel));
                expect_result("pipeline first", -1, info & info_mask(2), 2'd1, 1'b1);
                expect_result("pipeline second", -1, cw & info_mask(2), 2'd1, 1'b1);

                $display("Testbench passed");
                $finish;
        end

endmodule

//--- vlog.f
hw/ecc_code_pkg.sv
hw/apb_map_pkg.sv
hw/ecc_ctrl_if.sv
hw/apb_reg_bank.sv
hw/ecc_encoder.sv
hw/ecc_decoder.sv
hw/ecc_datapath.sv
hw/ecc_codec_top.sv
verification/ecc_codec_tb.sv
